// File: Makefile
# Verilator build and run of the playback testbench
# run passes only when the log holds the pass line

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f src.f --top-module tb_audio_playback -o tb_audio_playback

run: compile
	./obj_dir/tb_audio_playback | tee run.log
	grep -q "^RESULT: PASS$$" run.log

clean:
	rm -rf obj_dir run.log

// File: design/audio_cfg.svh
/*
 project-wide constants for the audio playback path
 include wherever clock rate, accumulator width or FIFO size is needed
 the types live in the two audio packages
*/
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// audio clock in Hz, 40 ns period
`define AUDIO_CLK_HZ 25000000

// phase accumulator width of the sample tick generator
`define AUDIO_ACC_W 32

// sample FIFO size in words, keep it a power of two
`define AUDIO_FIFO_DEPTH 16
`define AUDIO_FIFO_AW 4 // log2 of the depth

`endif

// File: design/audio_ctrl_pkg.sv
/*
 control and status types of the playback subsystem
 rate codes, the run-time configuration struct and the status struct
 the configuration arrives as a level input on the top level
*/
package audio_ctrl_pkg;

	// standard sample rate codes
	typedef enum logic [2:0]
	{
		rate_8k = 3'd0,
		rate_16k = 3'd1,
		rate_22k05 = 3'd2, // 22.05 kHz
		rate_24k = 3'd3,
		rate_32k = 3'd4,
		rate_44k1 = 3'd5, // 44.1 kHz
		rate_47k25 = 3'd6, // 47.25 kHz
		rate_48k = 3'd7
	} sample_rate_e;

	// run-time playback configuration, 4 bits
	typedef struct packed
	{
		sample_rate_e rate; // tick rate of the generator
		audio_data_pkg::qtz_mode_e qtz_mode; // word layout of the stream
	} playback_cfg_t;

	// status seen from outside, 6 bits
	typedef struct packed
	{
		logic [4:0] fifo_level; // words held, 0 to 16
		logic underrun; // one-cycle pulse per missed sample
	} playback_status_t;

endpackage

// File: design/audio_dac_ctrler.sv
/*
 DAC controller, one sample per tick into a 12-bit offset-binary code
 sequence is wait -> latch -> output, so dac_out moves two cycles after the tick
 16-bit mode reads a word per tick and keeps its upper 12 bits
 8-bit mode reads a word every other tick, first byte now and second byte next tick
 an empty FIFO at fetch time plays code 0 and pulses underrun
*/
`timescale 1ns/1ps

module audio_dac_ctrler
(
	input logic audio_clk,
	input logic audio_resetn,
	input logic sample_tick,
	input audio_data_pkg::qtz_mode_e qtz_mode, // level
	output logic fifo_ren,
	input logic fifo_empty,
	input audio_data_pkg::audio_word_u fifo_dout,
	output logic [11:0] dac_out,
	output logic underrun // one cycle, during latch
);

	import audio_data_pkg::*;

	logic [2:0] seq_onehot; // [0] wait, [1] latch, [2] output
	logic fifo_empty_d; // empty flag one cycle late, seen in latch
	logic pair_half; // second byte of a pair is pending
	logic [7:0] saved_second; // held second byte
	logic [11:0] hold_code; // converted sample waiting for output
	logic need_word; // this sample comes from the FIFO

	// a word is needed in 16-bit mode or at the start of a pair
	assign need_word = (qtz_mode == qtz_16) | ~pair_half;

	assign fifo_ren = seq_onehot[0] & sample_tick & need_word;

	// fetch missed, pulse while latching
	assign underrun = seq_onehot[1] & need_word & fifo_empty_d;

	// sequencer, only wait needs a tick to move
	always_ff @(posedge audio_clk or negedge audio_resetn)
	begin
		if (!audio_resetn)
			seq_onehot <= 3'b001;
		else if ((seq_onehot[0] & sample_tick) | ~seq_onehot[0])
			seq_onehot <= {seq_onehot[1:0], seq_onehot[2]}; // rotate
	end

	// empty as seen in the tick cycle
	always_ff @(posedge audio_clk or negedge audio_resetn)
	begin
		if (!audio_resetn)
			fifo_empty_d <= 1'b0;
		else
			fifo_empty_d <= fifo_empty;
	end

	// pair tracking, stays put on an underrun
	always_ff @(posedge audio_clk or negedge audio_resetn)
	begin
		if (!audio_resetn)
			pair_half <= 1'b0;
		else if (seq_onehot[1] && !underrun)
			pair_half <= (qtz_mode == qtz_8) & ~pair_half;
	end

	// latch stage, payload only
	always_ff @(posedge audio_clk)
	begin
		if (seq_onehot[1])
		begin
			if (underrun)
				hold_code <= 12'd0; // nothing to play
			else if (qtz_mode == qtz_16)
				hold_code <= fifo_dout.pcm16[15:4]; // top 12 bits
			else if (!pair_half)
			begin
				hold_code <= {fifo_dout.pcm8_pair.first, 4'd0};
				saved_second <= fifo_dout.pcm8_pair.second; // for the next tick
			end
			else
				hold_code <= {saved_second, 4'd0}; // no read this tick
		end
	end

	// DAC output register
	always_ff @(posedge audio_clk or negedge audio_resetn)
	begin
		if (!audio_resetn)
			dac_out <= 12'd0;
		else if (seq_onehot[2])
			dac_out <= hold_code;
	end

endmodule

// File: design/audio_data_pkg.sv
/*
 sample data types shared by the FIFO and the DAC controller
 one FIFO word is read as a single 16-bit sample or as a pair of 8-bit samples
*/
package audio_data_pkg;

	// two 8-bit samples in one word, the first one played sits in the low byte
	typedef struct packed
	{
		logic [7:0] second; // upper byte, played on the odd tick
		logic [7:0] first; // lower byte, played first
	} pcm8_pair_t;

	// one FIFO word with its two decodings
	typedef union packed
	{
		logic [15:0] pcm16; // 16-bit unsigned sample
		pcm8_pair_t pcm8_pair; // two 8-bit unsigned samples
	} audio_word_u;

	// quantisation mode of the stream
	typedef enum logic
	{
		qtz_16 = 1'b0, // one sample per word
		qtz_8 = 1'b1 // two samples per word
	} qtz_mode_e;

endpackage

// File: design/audio_playback_top.sv
/*
 PCM playback subsystem top
 stream words go through the sample FIFO to the DAC controller
 the tick generator sets the pace from cfg.rate
 status carries the FIFO level and the underrun pulse
*/
`timescale 1ns/1ps

module audio_playback_top
(
	input logic audio_clk,
	input logic audio_resetn,
	input audio_ctrl_pkg::playback_cfg_t cfg, // rate and mode, level
	input logic in_valid,
	input audio_data_pkg::audio_word_u in_data,
	output logic in_ready,
	output logic [11:0] dac_out,
	output audio_ctrl_pkg::playback_status_t status
);

	import audio_data_pkg::*;

	logic sample_tick; // generator to controller
	logic fifo_ren;
	logic fifo_empty;
	audio_word_u fifo_dout;
	logic [4:0] fifo_level;
	logic underrun;

	audio_sample_gen u_sample_gen
	(
		.audio_clk(audio_clk),
		.audio_resetn(audio_resetn),
		.rate(cfg.rate),
		.sample_tick(sample_tick)
	);

	audio_sample_fifo u_fifo
	(
		.audio_clk(audio_clk),
		.audio_resetn(audio_resetn),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.fifo_ren(fifo_ren),
		.fifo_empty(fifo_empty),
		.fifo_dout(fifo_dout),
		.fifo_level(fifo_level)
	);

	audio_dac_ctrler u_dac_ctrler
	(
		.audio_clk(audio_clk),
		.audio_resetn(audio_resetn),
		.sample_tick(sample_tick),
		.qtz_mode(cfg.qtz_mode),
		.fifo_ren(fifo_ren),
		.fifo_empty(fifo_empty),
		.fifo_dout(fifo_dout),
		.dac_out(dac_out),
		.underrun(underrun)
	);

	assign status.fifo_level = fifo_level;
	assign status.underrun = underrun;

endmodule

// File: design/audio_sample_fifo.sv
/*
 sample word FIFO between the stream input and the DAC controller
 write side is valid/ready, in_ready drops while all words are taken
 read side is read enable plus empty, read data shows up one cycle
 after an enable that found the FIFO non-empty
*/
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_sample_fifo
(
	input logic audio_clk,
	input logic audio_resetn,
	input logic in_valid,
	input audio_data_pkg::audio_word_u in_data,
	output logic in_ready, // not full
	input logic fifo_ren,
	output logic fifo_empty,
	output audio_data_pkg::audio_word_u fifo_dout, // registered read data
	output logic [4:0] fifo_level // words held
);

	import audio_data_pkg::*;

	audio_word_u mem [`AUDIO_FIFO_DEPTH]; // storage, no reset
	logic [`AUDIO_FIFO_AW-1:0] wr_ptr; // wraps with the depth
	logic [`AUDIO_FIFO_AW-1:0] rd_ptr;
	logic [`AUDIO_FIFO_AW:0] count; // 0 to depth
	logic wr_en;
	logic rd_en;

	assign in_ready = (count != `AUDIO_FIFO_DEPTH);
	assign fifo_empty = (count == '0);
	assign fifo_level = count;

	assign wr_en = in_valid & in_ready; // handshake
	assign rd_en = fifo_ren & ~fifo_empty; // enable on empty is dropped

	// storage and read data
	always_ff @(posedge audio_clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= in_data;
		if (rd_en)
			fifo_dout <= mem[rd_ptr]; // valid one cycle later
	end

	// pointers and occupancy
	always_ff @(posedge audio_clk or negedge audio_resetn)
	begin
		if (!audio_resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
			// write and read together keep the level
		end
	end

endmodule

// File: design/audio_sample_gen.sv
/*
 sample tick generator for the DAC path
 a phase accumulator adds a rate-dependent increment every audio clock
 each carry out of the accumulator gives one sample_tick pulse one cycle wide
 fractional rates keep the right long-run average without a divider
*/
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_sample_gen
(
	input logic audio_clk,
	input logic audio_resetn,
	input audio_ctrl_pkg::sample_rate_e rate, // rate code, level
	output logic sample_tick // one cycle per sample
);

	import audio_ctrl_pkg::*;

	// inc = rate * 2^W / f_clk, fraction dropped
	function automatic logic [`AUDIO_ACC_W-1:0] phase_inc(input longint unsigned rate_hz);
		longint unsigned scaled;
		scaled = (rate_hz << `AUDIO_ACC_W) / `AUDIO_CLK_HZ;
		return scaled[`AUDIO_ACC_W-1:0];
	endfunction

	localparam logic [`AUDIO_ACC_W-1:0] inc_8k = phase_inc(8000);
	localparam logic [`AUDIO_ACC_W-1:0] inc_16k = phase_inc(16000);
	localparam logic [`AUDIO_ACC_W-1:0] inc_22k05 = phase_inc(22050);
	localparam logic [`AUDIO_ACC_W-1:0] inc_24k = phase_inc(24000);
	localparam logic [`AUDIO_ACC_W-1:0] inc_32k = phase_inc(32000);
	localparam logic [`AUDIO_ACC_W-1:0] inc_44k1 = phase_inc(44100);
	localparam logic [`AUDIO_ACC_W-1:0] inc_47k25 = phase_inc(47250);
	localparam logic [`AUDIO_ACC_W-1:0] inc_48k = phase_inc(48000);

	logic [`AUDIO_ACC_W-1:0] inc; // increment for the current rate
	logic [`AUDIO_ACC_W-1:0] acc; // phase
	logic [`AUDIO_ACC_W:0] acc_sum; // phase plus increment with carry

	// rate table, a new code is used by the very next addition
	always_comb
	begin
		case (rate)
			rate_8k: inc = inc_8k;
			rate_16k: inc = inc_16k;
			rate_22k05: inc = inc_22k05;
			rate_24k: inc = inc_24k;
			rate_32k: inc = inc_32k;
			rate_44k1: inc = inc_44k1;
			rate_47k25: inc = inc_47k25;
			rate_48k: inc = inc_48k;
			default: inc = inc_8k; // unreachable with a 3-bit code
		endcase
	end

	assign acc_sum = {1'b0, acc} + {1'b0, inc};

	// accumulator and registered carry
	always_ff @(posedge audio_clk or negedge audio_resetn)
	begin
		if (!audio_resetn)
		begin
			acc <= '0; // phase starts at zero
			sample_tick <= 1'b0;
		end
		else
		begin
			acc <= acc_sum[`AUDIO_ACC_W-1:0]; // wraps modulo 2^W
			sample_tick <= acc_sum[`AUDIO_ACC_W]; // high in the cycle after a wrap
		end
	end

endmodule

// File: dv/tb_audio_playback.sv
/*
 directed testbench for the PCM playback subsystem
 each test resets the DUT, drives the stream input and checks dac_out and status
 a monitor compares every change of dac_out with the code predicted from the pushed words
*/
`timescale 1ns/1ps
`include "audio_cfg.svh"

module tb_audio_playback;

	import audio_data_pkg::*;
	import audio_ctrl_pkg::*;

	localparam int n_run = 20000; // cycles per rate code in the underrun test
	localparam int rate_table [8] = '{8000, 16000, 22050, 24000, 32000, 44100, 47250, 48000};
	// 10 and 10 played codes plus at most 39 underruns per rate code plus one freeing tick
	localparam int planned_ticks = 10 + 10 + 8 * 39 + 1;
	// each tick at most one 8 kHz period of 3125 cycles with 20 % margin
	localparam longint watchdog_ns = longint'(planned_ticks) * 3125 * 40 * 12 / 10;

	logic audio_clk;
	logic audio_resetn;
	playback_cfg_t cfg;
	logic in_valid;
	audio_word_u in_data;
	logic in_ready;
	logic [11:0] dac_out;
	playback_status_t status;

	audio_word_u exp_words [$]; // pushed but not fully played yet
	logic model_half; // second byte of the head word is next
	logic [11:0] played_first; // first code of the current pair
	logic [11:0] last_dac;
	logic mon_en; // dac_out monitor on
	int n_checks = 0;
	int n_errors = 0;

	audio_playback_top u_dut (.*);

	initial
	begin
		audio_clk = 1'b0;
		forever
			#20 audio_clk = ~audio_clk; // 25 MHz
	end

	initial
	begin
		#(watchdog_ns);
		$display("timeout: tests still running after %0d ns", watchdog_ns);
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic report(input string msg);
		n_errors++;
		$display("%s", msg);
	endtask

	task automatic check_dac(input string name, input logic [11:0] got, input logic [11:0] exp);
		n_checks++;
		if (got !== exp)
			report($sformatf("mismatch at %0t ns: %s expected %h got %h",
				$time, name, exp, got));
	endtask

	task automatic check_status(input string name, input playback_status_t got,
		input playback_status_t exp);
		string exp_s;
		string got_s;
		n_checks++;
		exp_s = $sformatf("level %0d underrun %b", exp.fifo_level, exp.underrun);
		got_s = $sformatf("level %0d underrun %b", got.fifo_level, got.underrun);
		if (got !== exp)
			report($sformatf("mismatch at %0t ns: %s expected %s got %s",
				$time, name, exp_s, got_s));
	endtask

	task automatic check_word(input string name, input audio_word_u got, input audio_word_u exp);
		n_checks++;
		if (got !== exp)
			report($sformatf("mismatch at %0t ns: %s expected %h got %h",
				$time, name, exp.pcm16, got.pcm16));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		n_checks++;
		if (got != exp)
			report($sformatf("mismatch at %0t ns: %s expected %0d got %0d",
				$time, name, exp, got));
	endtask

	task automatic step_clk;
		@(posedge audio_clk);
		#2; // drive point
	endtask

	task automatic apply_reset(input playback_cfg_t c);
		mon_en = 1'b0;
		in_valid = 1'b0;
		cfg = c; // level input stable before reset ends
		exp_words.delete();
		model_half = 1'b0;
		audio_resetn = 1'b0;
		repeat (5)
			@(posedge audio_clk);
		#2 audio_resetn = 1'b1; // next edge is accumulator addition 1
	endtask

	// random word whose codes all differ from the one before so each one moves dac_out
	function automatic audio_word_u draw_word(input qtz_mode_e mode, input logic [11:0] prev);
		audio_word_u w;
		int unsigned r;
		do
		begin
			r = $urandom;
			w.pcm16 = r[15:0];
		end
		while ((mode == qtz_16) ? (w.pcm16[15:4] == prev)
			: (w.pcm8_pair.first == prev[11:4] || w.pcm8_pair.second == w.pcm8_pair.first));
		return w;
	endfunction

	task automatic push_word(input audio_word_u w);
		in_valid = 1'b1;
		in_data = w;
		repeat (100)
			if (!in_ready)
				step_clk(); // wait for room
		if (!in_ready)
			report($sformatf("error at %0t ns: in_ready stayed low, word not taken", $time));
		step_clk(); // handshake on this edge
		in_valid = 1'b0;
		exp_words.push_back(w);
	endtask

	// reference model with one expected code per dac_out change
	always @(posedge audio_clk)
	begin : dac_monitor
		audio_word_u head;
		audio_word_u rebuilt;
		#1;
		if (mon_en && dac_out !== last_dac)
		begin
			if (exp_words.size() == 0)
				report($sformatf("error at %0t ns: dac_out moved to %h with no sample pending",
					$time, dac_out));
			else
			begin
				head = exp_words[0];
				if (cfg.qtz_mode == qtz_16)
				begin
					check_dac("dac_out", dac_out, head.pcm16[15:4]); // top 12 bits
					void'(exp_words.pop_front());
				end
				else if (!model_half)
				begin
					check_dac("dac_out", dac_out, {head.pcm8_pair.first, 4'h0});
					played_first = dac_out;
					model_half = 1'b1;
				end
				else
				begin
					check_dac("dac_out", dac_out, {head.pcm8_pair.second, 4'h0});
					rebuilt.pcm8_pair = {dac_out[11:4], played_first[11:4]}; // second then first
					check_word("played pair", rebuilt, head);
					void'(exp_words.pop_front());
					model_half = 1'b0;
				end
			end
		end
		last_dac = dac_out;
	end

	task automatic reset_state;
		apply_reset(playback_cfg_t'({rate_48k, qtz_16}));
		check_dac("dac_out", dac_out, 12'd0);
		check_count("in_ready", int'(in_ready), 1);
		check_status("status", status, playback_status_t'({5'd0, 1'b0}));
	endtask

	// push a burst at 48 kHz and wait until every code has been played
	task automatic play_words(input qtz_mode_e mode, input int n_words);
		logic [11:0] prev;
		audio_word_u w;
		apply_reset(playback_cfg_t'({rate_48k, mode}));
		mon_en = 1'b1;
		prev = 12'd0; // dac_out after reset
		repeat (n_words)
		begin
			w = draw_word(mode, prev);
			prev = (mode == qtz_16) ? w.pcm16[15:4] : {w.pcm8_pair.second, 4'h0};
			push_word(w);
		end
		repeat (3125 * 12)
			if (exp_words.size() != 0)
				step_clk();
		if (exp_words.size() != 0)
			report($sformatf("error at %0t ns: %0d words never reached dac_out",
				$time, exp_words.size()));
		mon_en = 1'b0;
		check_status("status", status, playback_status_t'({5'd0, 1'b0}));
	endtask

	task automatic play_16bit;
		play_words(qtz_16, 10);
	endtask

	task automatic play_8bit_pairs;
		play_words(qtz_8, 5);
	endtask

	// FIFO stays empty so every tick is an underrun
	task automatic underrun_and_rate;
		longint unsigned inc;
		int exp_cnt;
		int cnt;
		for (int r = 0; r < 8; r++)
		begin
			apply_reset(playback_cfg_t'({sample_rate_e'(r), qtz_16}));
			inc = (longint'(rate_table[r]) << `AUDIO_ACC_W) / `AUDIO_CLK_HZ;
			exp_cnt = int'((longint'(n_run) * inc) >> `AUDIO_ACC_W);
			cnt = 0;
			for (int j = 1; j <= n_run + 1; j++)
			begin
				@(posedge audio_clk);
				#1;
				if (j >= 2 && status.underrun) // pulse trails its carry by one cycle
				begin
					cnt++;
					check_dac("dac_out", dac_out, 12'd0);
				end
			end
			#1;
			check_count($sformatf("underrun pulses, rate code %0d", r), cnt, exp_cnt);
		end
	endtask

	task automatic back_pressure;
		int accepted = 0;
		int n = 0;
		apply_reset(playback_cfg_t'({rate_8k, qtz_16}));
		while (in_ready && accepted < 20)
		begin
			in_valid = 1'b1;
			in_data = draw_word(qtz_16, 12'd0);
			step_clk();
			accepted++;
		end
		in_valid = 1'b0;
		check_count("words accepted", accepted, 16);
		check_status("status", status, playback_status_t'({5'd16, 1'b0}));
		while (!in_ready && n < 2 * 3125)
		begin
			step_clk(); // first tick frees one word
			n++;
		end
		check_count("in_ready", int'(in_ready), 1);
		check_status("status", status, playback_status_t'({5'd15, 1'b0}));
	endtask

	initial
	begin
		void'($urandom(33581)); // fixed seed for sample values
		audio_resetn = 1'b0;
		cfg = playback_cfg_t'({rate_8k, qtz_16});
		in_valid = 1'b0;
		in_data = '0;
		mon_en = 1'b0;
		last_dac = 12'd0;
		reset_state();
		play_16bit();
		play_8bit_pairs();
		underrun_and_rate();
		back_pressure();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/audio_data_pkg.sv
design/audio_ctrl_pkg.sv
design/audio_sample_gen.sv
design/audio_sample_fifo.sv
design/audio_dac_ctrler.sv
design/audio_playback_top.sv
dv/tb_audio_playback.sv
